// ==== src/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

   // Default widths of the APB and IOb buses
   localparam int DEF_ADDR_W = 32;
   localparam int DEF_DATA_W = 32;

   localparam int BYTE_W = 8;
   localparam int DEF_STRB_W = DEF_DATA_W / BYTE_W;  // One lane per byte

   // Byte address on both buses
   typedef logic [DEF_ADDR_W-1:0] addr_t;

   // Data word, read and write
   typedef logic [DEF_DATA_W-1:0] data_t;

   // Byte-lane write enables, all zero on a read
   typedef logic [DEF_STRB_W-1:0] strb_t;

endpackage

`default_nettype wire

// ==== src/regmap_pkg.sv ====
`default_nettype none

package regmap_pkg;

   // Eight 32-bit words in the bank
   localparam int REG_NUM = 8;
   localparam int IDX_W   = $clog2(REG_NUM);
   localparam int IDX_LSB = 2;  // Words are byte addressed, low two bits ignored

   typedef logic [IDX_W-1:0] reg_idx_t;

   // Word map
   localparam reg_idx_t IDX_WAIT = 3'd6;  // Wait states inserted by the bank
   localparam reg_idx_t IDX_ID   = 3'd7;  // Read-only identification

   // Indices 0 up to IDX_WAIT-1 are scratch words
   localparam int SCRATCH_NUM = 6;

   // Only the low bits of the wait register are kept
   localparam int WAIT_W = 2;

   typedef logic [WAIT_W-1:0] wait_t;

   localparam logic [31:0] ID_VALUE = 32'h10B0_A9B1;

   // Reset values
   localparam logic [31:0] SCRATCH_RST = 32'h0000_0000;
   localparam wait_t       WAIT_RST    = 2'd0;  // No wait states out of reset

endpackage

`default_nettype wire

// ==== src/apb_iob_bridge.sv ====
`default_nettype none

module apb_iob_bridge
   import bus_pkg::*;
#(
   parameter int ADDR_W = DEF_ADDR_W,
   parameter int DATA_W = DEF_DATA_W
) (
   input  wire        clk_i,
   input  wire        rst_n_i,

   // APB slave side
   input  wire        apb_sel_i,
   input  wire        apb_enable_i,
   input  wire        apb_write_i,
   input  wire addr_t apb_addr_i,
   input  wire data_t apb_wdata_i,
   input  wire strb_t apb_wstrb_i,
   output logic       apb_ready_o,
   output data_t      apb_rdata_o,
   output logic       apb_slverr_o,

   // IOb master side
   output logic       iob_avalid_o,
   output addr_t      iob_addr_o,
   output data_t      iob_wdata_o,
   output strb_t      iob_wstrb_o,
   input  wire        iob_ready_nxt_i,
   input  wire        iob_rvalid_nxt_i,
   input  wire data_t iob_rdata_i
);

   typedef enum logic [1:0] {
      IDLE,
      ISSUE,
      FINISH
   } phase_t;

   phase_t phase_q;
   phase_t phase_nxt;
   logic   avalid_nxt;
   logic   slverr_nxt;
   logic   ready_nxt;

   // Write ends on acceptance, read when the bank returns data
   assign ready_nxt = apb_write_i ? (iob_avalid_o & iob_ready_nxt_i)
                                  : iob_rvalid_nxt_i;

   always_comb begin
      phase_nxt  = phase_q;
      avalid_nxt = iob_avalid_o;
      slverr_nxt = 1'b0;

      case (phase_q)
         IDLE: begin
            if (apb_sel_i) begin  // Setup phase seen
               avalid_nxt = 1'b1;
               phase_nxt  = ISSUE;
            end
         end

         ISSUE: begin
            // Enable should follow setup, flag it and keep the flag until the end
            slverr_nxt = apb_slverr_o | ~apb_enable_i;
            if (iob_ready_nxt_i) begin
               avalid_nxt = 1'b0;  // Accepted at this edge
               phase_nxt  = FINISH;
            end
         end

         default: begin
            if (!apb_sel_i)
               phase_nxt = IDLE;  // Master closed the transfer
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         phase_q      <= IDLE;
         iob_avalid_o <= 1'b0;
         apb_ready_o  <= 1'b0;
         apb_slverr_o <= 1'b0;
      end else begin
         phase_q      <= phase_nxt;
         iob_avalid_o <= avalid_nxt;
         apb_ready_o  <= ready_nxt;
         apb_slverr_o <= slverr_nxt;
      end
   end

   // Read data is already registered in the bank
   assign apb_rdata_o = iob_rdata_i;

   // Master holds address and data stable until ready
   assign iob_addr_o  = apb_addr_i[ADDR_W-1:0];
   assign iob_wdata_o = apb_wdata_i;
   assign iob_wstrb_o = apb_wstrb_i & {(DATA_W/8){apb_write_i}};  // No lanes on a read

endmodule

`default_nettype wire

// ==== src/iob_reg_bank.sv ====
`default_nettype none

module iob_reg_bank
   import bus_pkg::*;
   import regmap_pkg::*;
#(
   parameter int ADDR_W = DEF_ADDR_W,
   parameter int DATA_W = DEF_DATA_W
) (
   input  wire        clk_i,
   input  wire        rst_n_i,

   // IOb slave side
   input  wire        iob_avalid_i,
   input  wire addr_t iob_addr_i,
   input  wire data_t iob_wdata_i,
   input  wire strb_t iob_wstrb_i,
   output logic       iob_ready_nxt_o,
   output logic       iob_rvalid_nxt_o,
   output data_t      iob_rdata_o
);

   localparam int STRB_W = DATA_W / BYTE_W;

   reg_idx_t idx;
   logic     out_of_range;
   logic     accept;
   logic     wr_en;
   logic     rd_en;
   wait_t    wait_q;      // Stored wait setting
   wait_t    wait_cnt_q;  // avalid cycles spent so far
   logic     rvalid_q;
   data_t    rdata_q;
   data_t    rd_word;
   data_t    scratch_q [SCRATCH_NUM];

   // Word select, anything above the map is out of range
   assign idx          = iob_addr_i[IDX_LSB +: IDX_W];
   assign out_of_range = |iob_addr_i[ADDR_W-1:IDX_LSB+IDX_W];

   // Ready after exactly wait_q cycles of avalid
   assign iob_ready_nxt_o = iob_avalid_i & (wait_cnt_q == wait_q);

   assign accept = iob_ready_nxt_o;  // Already qualified by avalid
   assign wr_en  = accept & (|iob_wstrb_i);
   assign rd_en  = accept & ~(|iob_wstrb_i);

   assign iob_rvalid_nxt_o = rd_en;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wait_cnt_q <= '0;
      end else if (iob_avalid_i && !iob_ready_nxt_o) begin
         wait_cnt_q <= wait_cnt_q + 1'b1;
      end else begin
         wait_cnt_q <= '0;  // Idle or accepted, restart for the next one
      end
   end

   // Read mux
   always_comb begin
      rd_word = '0;
      if (!out_of_range) begin
         case (idx)
            IDX_ID:   rd_word = ID_VALUE;
            IDX_WAIT: rd_word = data_t'(wait_q);
            default:  rd_word = scratch_q[idx];
         endcase
      end
   end

   // Strobed writes, ID word and out-of-range addresses are left alone
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < SCRATCH_NUM; i++) begin
            scratch_q[i] <= SCRATCH_RST;
         end
         wait_q <= WAIT_RST;
      end else if (wr_en && !out_of_range) begin
         if (idx == IDX_WAIT) begin
            if (iob_wstrb_i[0]) begin
               wait_q <= iob_wdata_i[WAIT_W-1:0];  // Used from the next transaction
            end
         end else if (idx != IDX_ID) begin
            for (int b = 0; b < STRB_W; b++) begin
               if (iob_wstrb_i[b]) begin
                  scratch_q[idx][b*BYTE_W +: BYTE_W] <= iob_wdata_i[b*BYTE_W +: BYTE_W];
               end
            end
         end
      end
   end

   // Read response one cycle after acceptance
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_en;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         rdata_q <= rd_word;
      end
   end

   // Data bus is quiet outside the response cycle
   assign iob_rdata_o = rvalid_q ? rdata_q : '0;

endmodule

`default_nettype wire

// ==== src/apb_periph_top.sv ====
`default_nettype none

module apb_periph_top
   import bus_pkg::*;
#(
   parameter int ADDR_W = DEF_ADDR_W,
   parameter int DATA_W = DEF_DATA_W
) (
   input  wire        clk_i,
   input  wire        rst_n_i,

   // APB slave port
   input  wire        apb_sel_i,
   input  wire        apb_enable_i,
   input  wire        apb_write_i,
   input  wire addr_t apb_addr_i,
   input  wire data_t apb_wdata_i,
   input  wire strb_t apb_wstrb_i,
   output logic       apb_ready_o,
   output data_t      apb_rdata_o,
   output logic       apb_slverr_o
);

   // Internal IOb bus, bridge to bank
   logic  iob_avalid;
   addr_t iob_addr;
   data_t iob_wdata;
   strb_t iob_wstrb;
   logic  iob_ready_nxt;
   logic  iob_rvalid_nxt;
   data_t iob_rdata;

   apb_iob_bridge #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) u_bridge (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .apb_sel_i       (apb_sel_i),
      .apb_enable_i    (apb_enable_i),
      .apb_write_i     (apb_write_i),
      .apb_addr_i      (apb_addr_i),
      .apb_wdata_i     (apb_wdata_i),
      .apb_wstrb_i     (apb_wstrb_i),
      .apb_ready_o     (apb_ready_o),
      .apb_rdata_o     (apb_rdata_o),
      .apb_slverr_o    (apb_slverr_o),
      .iob_avalid_o    (iob_avalid),
      .iob_addr_o      (iob_addr),
      .iob_wdata_o     (iob_wdata),
      .iob_wstrb_o     (iob_wstrb),
      .iob_ready_nxt_i (iob_ready_nxt),
      .iob_rvalid_nxt_i(iob_rvalid_nxt),
      .iob_rdata_i     (iob_rdata)
   );

   // Register bank, wait states set at run time
   iob_reg_bank #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) u_bank (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .iob_avalid_i    (iob_avalid),
      .iob_addr_i      (iob_addr),
      .iob_wdata_i     (iob_wdata),
      .iob_wstrb_i     (iob_wstrb),
      .iob_ready_nxt_o (iob_ready_nxt),
      .iob_rvalid_nxt_o(iob_rvalid_nxt),
      .iob_rdata_o     (iob_rdata)
   );

endmodule

`default_nettype wire

// ==== bench/apb_periph_properties.sv ====
`default_nettype none

module apb_periph_properties
   import bus_pkg::*;
(
   input wire        clk_i,
   input wire        rst_n_i,
   input wire        apb_sel_i,
   input wire        apb_write_i,
   input wire        apb_ready_i,
   input wire        iob_avalid_i,
   input wire addr_t iob_addr_i,
   input wire strb_t iob_wstrb_i,
   input wire        iob_ready_nxt_i
);

   timeunit 1ns;
   timeprecision 1ps;

   // A pending IOb request keeps avalid and its address until the bank takes it
   a_avalid_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      iob_avalid_i && !iob_ready_nxt_i |=> iob_avalid_i && $stable(iob_addr_i))
      else $error("IOb avalid or address changed before the bank accepted the request");

   a_ready_in_sel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      apb_ready_i |-> apb_sel_i)
      else $error("APB ready is high while the slave is not selected");

   // Read response on APB only one cycle after the bank accepted a read with no lanes set
   a_rvalid_after_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      apb_ready_i && !apb_write_i |->
         $past(iob_avalid_i && iob_ready_nxt_i && (iob_wstrb_i == '0)))
      else $error("APB read completed without an accepted IOb read");

endmodule

bind apb_periph_top apb_periph_properties u_props (
   .clk_i          (clk_i),
   .rst_n_i        (rst_n_i),
   .apb_sel_i      (apb_sel_i),
   .apb_write_i    (apb_write_i),
   .apb_ready_i    (apb_ready_o),
   .iob_avalid_i   (iob_avalid),
   .iob_addr_i     (iob_addr),
   .iob_wstrb_i    (iob_wstrb),
   .iob_ready_nxt_i(iob_ready_nxt)
);

`default_nettype wire

// ==== bench/apb_periph_tb.sv ====
`default_nettype none

module apb_periph_tb
   import bus_pkg::*;
   import regmap_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int          CLK_PERIOD  = 40;
   localparam int          RST_CYCLES  = 16;
   localparam int          DRIVE_DLY   = 1;
   localparam int          READY_LIMIT = 12;  // Three wait states need about six
   localparam logic [31:0] SEED        = 32'h5df5_facd;

   typedef struct packed {
      logic  wr;
      addr_t addr;
      data_t wdata;
      strb_t strb;
      logic  skip;   // Leave out the enable phase
      data_t rdata;
      logic  err;
   } test_t;

   logic  clk;
   logic  rst_n;
   logic  apb_sel;
   logic  apb_enable;
   logic  apb_write;
   addr_t apb_addr;
   data_t apb_wdata;
   strb_t apb_wstrb;
   logic  apb_ready;
   data_t apb_rdata;
   logic  apb_slverr;
   test_t tests_q[$];
   string names_q[$];
   logic  tests_loaded;

   apb_periph_top #(
      .ADDR_W(DEF_ADDR_W),
      .DATA_W(DEF_DATA_W)
   ) u_dut (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .apb_sel_i   (apb_sel),
      .apb_enable_i(apb_enable),
      .apb_write_i (apb_write),
      .apb_addr_i  (apb_addr),
      .apb_wdata_i (apb_wdata),
      .apb_wstrb_i (apb_wstrb),
      .apb_ready_o (apb_ready),
      .apb_rdata_o (apb_rdata),
      .apb_slverr_o(apb_slverr)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic addr_t word_addr(input int idx);
      return addr_t'(idx * 4);
   endfunction

   // Old word with the strobed bytes replaced
   function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input strb_t strb);
      data_t res;
      res = old_w;
      for (int b = 0; b < $bits(strb_t); b++) begin
         if (strb[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
      end
      return res;
   endfunction

   task automatic add_test(input string name, input logic wr, input addr_t addr,
                           input data_t wdata, input strb_t strb, input logic skip,
                           input data_t rdata, input logic err);
      test_t t;
      t = '{wr, addr, wdata, strb, skip, rdata, err};
      tests_q.push_back(t);
      names_q.push_back(name);
   endtask

   task automatic check_value(input string name, input data_t expected, input data_t actual);
      if (actual !== expected) begin
         $display("Mismatch %s expected %h actual %h", name, expected, actual);
         $display("*** TEST FAILED ***");
         $fatal(1);
      end
   endtask

   // Setup phase, access phase, then wait for ready sampled mid-cycle
   task automatic apb_transfer(input test_t t, output data_t rdata, output logic slverr,
                               output logic done);
      int cnt;
      done   = 1'b0;
      cnt    = 0;
      rdata  = '0;
      slverr = 1'b0;
      @(posedge clk);
      #DRIVE_DLY;
      apb_sel    = 1'b1;
      apb_enable = 1'b0;
      apb_write  = t.wr;
      apb_addr   = t.addr;
      apb_wdata  = t.wr ? t.wdata : data_t'($urandom());
      apb_wstrb  = t.strb;
      @(posedge clk);
      #DRIVE_DLY;
      apb_enable = !t.skip;
      while (!done && cnt < READY_LIMIT) begin
         @(negedge clk);
         if (apb_ready) begin
            done   = 1'b1;
            rdata  = apb_rdata;
            slverr = apb_slverr;
         end
         cnt++;
      end
      @(posedge clk);
      #DRIVE_DLY;
      apb_sel    = 1'b0;
      apb_enable = 1'b0;
      apb_write  = 1'b0;
   endtask

   task automatic load_tests();
      data_t s5;
      data_t wait_wdata;
      for (int i = 0; i < SCRATCH_NUM; i++) begin
         add_test($sformatf("reset_scratch%0d", i), 0, word_addr(i), '0, '0, 0, SCRATCH_RST, 0);
      end
      add_test("reset_wait", 0, word_addr(IDX_WAIT), '0, '0, 0, data_t'(WAIT_RST), 0);
      add_test("reset_id", 0, word_addr(IDX_ID), '0, '0, 0, ID_VALUE, 0);
      add_test("wr_s0", 1, word_addr(0), 32'hDEAD_BEEF, 4'hF, 0, '0, 0);
      add_test("rd_s0", 0, word_addr(0), '0, '0, 0, 32'hDEAD_BEEF, 0);
      s5 = 32'hA5A5_5A5A;
      add_test("wr_s5", 1, word_addr(5), s5, 4'hF, 0, '0, 0);
      add_test("wr_s5_lanes02", 1, word_addr(5), 32'h1122_3344, 4'b0101, 0, '0, 0);
      s5 = merge_bytes(s5, 32'h1122_3344, 4'b0101);
      add_test("rd_s5_lanes02", 0, word_addr(5), '0, '0, 0, s5, 0);
      add_test("wr_s5_lane3", 1, word_addr(5), 32'h7788_99AA, 4'b1000, 0, '0, 0);
      s5 = merge_bytes(s5, 32'h7788_99AA, 4'b1000);
      add_test("rd_s5_lane3", 0, word_addr(5), '0, '0, 0, s5, 0);
      add_test("wr_id", 1, word_addr(IDX_ID), 32'hFFFF_FFFF, 4'hF, 0, '0, 0);
      add_test("rd_id_after_wr", 0, word_addr(IDX_ID), '0, '0, 0, ID_VALUE, 0);
      // Bit 5 set aliases word 0 unless the range check holds
      add_test("wr_out_of_range", 1, 32'h0000_0020, 32'hCAFE_F00D, 4'hF, 0, '0, 0);
      add_test("rd_out_of_range", 0, 32'h0000_0020, '0, '0, 0, '0, 0);
      add_test("rd_top_bit", 0, 32'h8000_0000, '0, '0, 0, '0, 0);  // Would alias word 0
      add_test("rd_s0_after_oor", 0, word_addr(0), '0, '0, 0, 32'hDEAD_BEEF, 0);
      for (int w = 1; w <= 3; w++) begin
         wait_wdata = 32'hFFFF_FFF0 | w;
         add_test($sformatf("wr_wait%0d", w), 1, word_addr(IDX_WAIT), wait_wdata, 4'hF, 0, '0, 0);
         add_test($sformatf("rd_wait%0d", w), 0, word_addr(IDX_WAIT), '0, '0, 0,
                  wait_wdata & 32'h3, 0);  // Upper bits dropped
         add_test($sformatf("wr_s1_wait%0d", w), 1, word_addr(1), 32'h0101_0101 * w, 4'hF, 0,
                  '0, 0);
         add_test($sformatf("rd_s1_wait%0d", w), 0, word_addr(1), '0, '0, 0, 32'h0101_0101 * w, 0);
         add_test($sformatf("rd_s5_wait%0d", w), 0, word_addr(5), '0, '0, 0, s5, 0);
      end
      add_test("rd_s0_skip_wait3", 0, word_addr(0), '0, '0, 1, '0, 1);
      add_test("rd_s0_after_skip", 0, word_addr(0), '0, '0, 0, 32'hDEAD_BEEF, 0);
      add_test("wr_wait0", 1, word_addr(IDX_WAIT), '0, 4'hF, 0, '0, 0);
      add_test("rd_wait0", 0, word_addr(IDX_WAIT), '0, '0, 0, '0, 0);
      add_test("rd_id_skip_wait0", 0, word_addr(IDX_ID), '0, '0, 1, '0, 1);
      add_test("rd_id_final", 0, word_addr(IDX_ID), '0, '0, 0, ID_VALUE, 0);
   endtask

   initial begin
      test_t t;
      data_t rdata;
      logic  slverr;
      logic  done;
      void'($urandom(SEED));
      clk          = 1'b0;
      rst_n        = 1'b0;
      apb_sel      = 1'b0;
      apb_enable   = 1'b0;
      apb_write    = 1'b0;
      apb_addr     = '0;
      apb_wdata    = '0;
      apb_wstrb    = '0;
      tests_loaded = 1'b0;
      load_tests();
      tests_loaded = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      #DRIVE_DLY rst_n = 1'b1;
      for (int i = 0; i < tests_q.size(); i++) begin
         t = tests_q[i];
         apb_transfer(t, rdata, slverr, done);
         if (!done) begin
            $display("Transfer %s never completed, no apb_ready_o within %0d cycles",
                     names_q[i], READY_LIMIT);
            $display("*** TEST FAILED ***");
            $fatal(1);
         end
         if (!t.wr && !t.skip) check_value({names_q[i], " rdata"}, t.rdata, rdata);
         check_value({names_q[i], " slverr"}, data_t'(t.err), data_t'(slverr));
      end
      $display("*** TEST PASSED ***");
      $finish;
   end

   // Each transfer takes well under twenty cycles
   initial begin
      wait (tests_loaded === 1'b1);
      repeat (tests_q.size() * 20 + RST_CYCLES) @(posedge clk);
      $display("Watchdog expired before the test table finished");
      $display("*** TEST FAILED ***");
      $fatal(1);
   end

endmodule

`default_nettype wire

// ==== build.f ====
src/bus_pkg.sv
src/regmap_pkg.sv
src/apb_iob_bridge.sv
src/iob_reg_bank.sv
src/apb_periph_top.sv
bench/apb_periph_properties.sv
bench/apb_periph_tb.sv
